// File: rtl/swu_cfg.svh
`ifndef SWU_CFG_SVH
`define SWU_CFG_SVH

//////////////////////////////////////////////////////////////////////
// word format
//////////////////////////////////////////////////////////////////////

// channels carried by one stream word
`define SWU_SIMD        4
// bits per channel value
`define SWU_PRECISION   4

//////////////////////////////////////////////////////////////////////
// image and kernel geometry
//////////////////////////////////////////////////////////////////////

`define SWU_IFM_W       5
`define SWU_IFM_H       5
`define SWU_CHANNELS    8
// words per input pixel, channels / simd
`define SWU_EFF_CH      2
`define SWU_K           3
`define SWU_OFM_W       3
`define SWU_OFM_H       3

//////////////////////////////////////////////////////////////////////
// buffer geometry
//////////////////////////////////////////////////////////////////////

// needs two input rows plus one kernel row of words (26)
`define SWU_BUF_WORDS   32
`define SWU_FRAME_IN    50

// address and word-index widths
`define SWU_ADDR_W      5
`define SWU_IDX_W       6

`endif

// File: rtl/swu_stream_pkg.sv
`default_nettype none

`include "swu_cfg.svh"

package swu_stream_pkg;

   // one channel value
   typedef logic [`SWU_PRECISION-1:0] elem_t;

   // one stream word, SIMD channels side by side
   typedef elem_t [`SWU_SIMD-1:0] word_t;

   // location in the circular window buffer
   typedef logic [`SWU_ADDR_W-1:0] buf_addr_t;

   // buffer write port
   typedef struct packed {
      logic      en;
      buf_addr_t addr;
      word_t     data;
   } wr_req_t;

   // buffer read port, data comes back one cycle later
   typedef struct packed {
      logic      en;
      buf_addr_t addr;
   } rd_req_t;

endpackage

`default_nettype wire

// File: rtl/swu_geom_pkg.sv
`default_nettype none

`include "swu_cfg.svh"

package swu_geom_pkg;

   // absolute word index inside one frame
   typedef logic [`SWU_IDX_W-1:0] word_idx_t;

   //////////////////////////////////////////////////////////////////////
   // position of the read pointer in the output traversal
   //////////////////////////////////////////////////////////////////////

   // oy and ox select the output pixel
   // kh and kw walk the kernel, ch the channel group of the pixel
   typedef struct packed {
      logic [$clog2(`SWU_OFM_H)-1:0]  oy;
      logic [$clog2(`SWU_OFM_W)-1:0]  ox;
      logic [$clog2(`SWU_K)-1:0]      kh;
      logic [$clog2(`SWU_K)-1:0]      kw;
      logic [$clog2(`SWU_EFF_CH)-1:0] ch;
   } win_pos_t;

endpackage

`default_nettype wire

// File: rtl/swu_input_ctrl.sv
`default_nettype none

`include "swu_cfg.svh"

module swu_input_ctrl (
   input  wire                       clk,
   input  wire                       resetn,
   input  swu_stream_pkg::word_t     in_tdata_i,
   input  wire                       in_tvalid_i,
   output logic                      in_tready_o,
   input  swu_geom_pkg::word_idx_t   win_base_i,
   input  wire                       frame_done_i,
   output swu_stream_pkg::wr_req_t   wr_req_o,
   output swu_geom_pkg::word_idx_t   written_o
);

   import swu_stream_pkg::*;
   import swu_geom_pkg::*;

   word_idx_t written_q;
   buf_addr_t wr_addr_q;
   word_idx_t space_limit;
   logic      in_hs;

   // highest index plus one that fits without overwriting the window
   assign space_limit = word_idx_t'(win_base_i + `SWU_BUF_WORDS);

   assign in_tready_o = (written_q < space_limit) &&
                        (written_q < word_idx_t'(`SWU_FRAME_IN));
   assign in_hs       = in_tvalid_i && in_tready_o;

   // write goes out in the handshake cycle
   always_comb begin
      wr_req_o.en   = in_hs;
      wr_req_o.addr = wr_addr_q;
      wr_req_o.data = in_tdata_i;
   end

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         written_q <= '0;
         wr_addr_q <= '0;
      end else if (in_hs) begin
         written_q <= written_q + 1'b1;
         if (wr_addr_q == buf_addr_t'(`SWU_BUF_WORDS - 1)) begin
            wr_addr_q <= '0;
         end else begin
            wr_addr_q <= wr_addr_q + 1'b1;
         end
      end
   end

   assign written_o = written_q;

endmodule

`default_nettype wire

// File: rtl/swu_window_ram.sv
`default_nettype none

`include "swu_cfg.svh"

module swu_window_ram (
   input  wire                       clk,
   input  swu_stream_pkg::wr_req_t   wr_req_i,
   input  swu_stream_pkg::rd_req_t   rd_req_i,
   output swu_stream_pkg::word_t     rd_data_o
);

   import swu_stream_pkg::*;

   word_t mem [`SWU_BUF_WORDS];
   word_t rd_data_q;

   always_ff @(posedge clk) begin
      if (wr_req_i.en) begin
         mem[wr_req_i.addr] <= wr_req_i.data;
      end
   end

   // registered read, the sequencer never reads the slot being written
   always_ff @(posedge clk) begin
      if (rd_req_i.en) begin
         rd_data_q <= mem[rd_req_i.addr];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: rtl/swu_window_seq.sv
`default_nettype none

`include "swu_cfg.svh"

module swu_window_seq (
   input  wire                       clk,
   input  wire                       resetn,
   input  swu_geom_pkg::word_idx_t   written_i,
   input  wire                       slot_free_i,
   output swu_stream_pkg::rd_req_t   rd_req_o,
   output logic                      rd_issue_o,
   output swu_geom_pkg::word_idx_t   win_base_o,
   output logic                      frame_done_o
);

   import swu_stream_pkg::*;
   import swu_geom_pkg::*;

   win_pos_t  pos_q;
   win_pos_t  pos_next;
   word_idx_t base_q;
   word_idx_t row_w;
   word_idx_t col_w;
   word_idx_t rd_idx;
   logic      ch_last;
   logic      kw_last;
   logic      kh_last;
   logic      ox_last;
   logic      oy_last;
   logic      win_done;
   logic      issue;

   //////////////////////////////////////////////////////////////////////
   // index of the next word to read
   //////////////////////////////////////////////////////////////////////

   assign row_w  = word_idx_t'(pos_q.oy) + word_idx_t'(pos_q.kh);
   assign col_w  = word_idx_t'(pos_q.ox) + word_idx_t'(pos_q.kw);
   assign rd_idx = word_idx_t'((row_w * `SWU_IFM_W + col_w) * `SWU_EFF_CH) +
                   word_idx_t'(pos_q.ch);

   // word must already be stored and the output queue must have room
   assign issue = (rd_idx < written_i) && slot_free_i;

   always_comb begin
      rd_req_o.en   = issue;
      rd_req_o.addr = buf_addr_t'(rd_idx % `SWU_BUF_WORDS);
   end

   //////////////////////////////////////////////////////////////////////
   // traversal counters
   //////////////////////////////////////////////////////////////////////

   assign ch_last  = pos_q.ch == ($bits(pos_q.ch))'(`SWU_EFF_CH - 1);
   assign kw_last  = pos_q.kw == ($bits(pos_q.kw))'(`SWU_K - 1);
   assign kh_last  = pos_q.kh == ($bits(pos_q.kh))'(`SWU_K - 1);
   assign ox_last  = pos_q.ox == ($bits(pos_q.ox))'(`SWU_OFM_W - 1);
   assign oy_last  = pos_q.oy == ($bits(pos_q.oy))'(`SWU_OFM_H - 1);
   assign win_done = ch_last && kw_last && kh_last;

   // ch fastest, then kw, kh, ox, oy
   always_comb begin
      pos_next = pos_q;
      if (!ch_last) begin
         pos_next.ch = pos_q.ch + 1'b1;
      end else begin
         pos_next.ch = '0;
         if (!kw_last) begin
            pos_next.kw = pos_q.kw + 1'b1;
         end else begin
            pos_next.kw = '0;
            if (!kh_last) begin
               pos_next.kh = pos_q.kh + 1'b1;
            end else begin
               pos_next.kh = '0;
               if (!ox_last) begin
                  pos_next.ox = pos_q.ox + 1'b1;
               end else begin
                  pos_next.ox = '0;
                  pos_next.oy = oy_last ? '0 : pos_q.oy + 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pos_q <= '0;
      end else if (issue) begin
         pos_q <= pos_next;
      end
   end

   // base moves one pixel per window, or to the next row start
   always_ff @(posedge clk) begin
      if (!resetn) begin
         base_q <= '0;
      end else if (issue && win_done) begin
         if (ox_last && oy_last) begin
            base_q <= '0;
         end else if (ox_last) begin
            base_q <= base_q +
                      word_idx_t'((`SWU_IFM_W - `SWU_OFM_W + 1) * `SWU_EFF_CH);
         end else begin
            base_q <= base_q + word_idx_t'(`SWU_EFF_CH);
         end
      end
   end

   assign rd_issue_o   = issue;
   assign win_base_o   = base_q;
   assign frame_done_o = issue && win_done && ox_last && oy_last;

endmodule

`default_nettype wire

// File: rtl/swu_output_stage.sv
`default_nettype none

module swu_output_stage (
   input  wire                       clk,
   input  wire                       resetn,
   input  wire                       rd_issue_i,
   input  swu_stream_pkg::word_t     rd_data_i,
   output logic                      slot_free_o,
   output swu_stream_pkg::word_t     out_tdata_o,
   output logic                      out_tvalid_o,
   input  wire                       out_tready_i
);

   import swu_stream_pkg::*;

   word_t      queue_q [2];
   logic [1:0] count_q;
   logic       inflight_q;
   logic       push;
   logic       pop;

   // ram data is valid the cycle after the read was issued
   always_ff @(posedge clk) begin
      if (!resetn) begin
         inflight_q <= 1'b0;
      end else begin
         inflight_q <= rd_issue_i;
      end
   end

   assign push = inflight_q;
   assign pop  = out_tvalid_o && out_tready_i;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= '0;
      end else if (push && !pop) begin
         count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
         count_q <= count_q - 1'b1;
      end
   end

   // head lives in entry 0
   always_ff @(posedge clk) begin
      if (pop) begin
         queue_q[0] <= (push && count_q == 2'd1) ? rd_data_i : queue_q[1];
         if (push && count_q == 2'd2) begin
            queue_q[1] <= rd_data_i;
         end
      end else if (push) begin
         queue_q[count_q[0]] <= rd_data_i;
      end
   end

   assign out_tdata_o  = queue_q[0];
   assign out_tvalid_o = count_q != 2'd0;

   // words queued plus the one in flight
   assign slot_free_o = (3'(count_q) + 3'(inflight_q)) < 3'd2;

endmodule

`default_nettype wire

// File: rtl/swu_top.sv
`default_nettype none

module swu_top (
   input  wire                       clk,
   input  wire                       resetn,
   input  swu_stream_pkg::word_t     in_tdata_i,
   input  wire                       in_tvalid_i,
   output logic                      in_tready_o,
   output swu_stream_pkg::word_t     out_tdata_o,
   output logic                      out_tvalid_o,
   input  wire                       out_tready_i
);

   import swu_stream_pkg::*;
   import swu_geom_pkg::*;

   wr_req_t   wr_req;
   rd_req_t   rd_req;
   word_t     rd_data;
   word_idx_t written;
   word_idx_t win_base;
   logic      frame_done;
   logic      rd_issue;
   logic      slot_free;

   swu_input_ctrl swu_input_ctrl_i (
      .clk          (clk),
      .resetn       (resetn),
      .in_tdata_i   (in_tdata_i),
      .in_tvalid_i  (in_tvalid_i),
      .in_tready_o  (in_tready_o),
      .win_base_i   (win_base),
      .frame_done_i (frame_done),
      .wr_req_o     (wr_req),
      .written_o    (written)
   );

   swu_window_ram swu_window_ram_i (
      .clk       (clk),
      .wr_req_i  (wr_req),
      .rd_req_i  (rd_req),
      .rd_data_o (rd_data)
   );

   swu_window_seq swu_window_seq_i (
      .clk          (clk),
      .resetn       (resetn),
      .written_i    (written),
      .slot_free_i  (slot_free),
      .rd_req_o     (rd_req),
      .rd_issue_o   (rd_issue),
      .win_base_o   (win_base),
      .frame_done_o (frame_done)
   );

   swu_output_stage swu_output_stage_i (
      .clk          (clk),
      .resetn       (resetn),
      .rd_issue_i   (rd_issue),
      .rd_data_i    (rd_data),
      .slot_free_o  (slot_free),
      .out_tdata_o  (out_tdata_o),
      .out_tvalid_o (out_tvalid_o),
      .out_tready_i (out_tready_i)
   );

endmodule

`default_nettype wire

// File: testbench/swu_tb.sv
`default_nettype none

`include "swu_cfg.svh"

module swu_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import swu_stream_pkg::*;

   localparam int clk_period = 40;
   localparam int reset_cycles = 16;
   localparam int rand_seed = 23785;
   localparam int n_rows = 5;
   localparam int frame_in = `SWU_FRAME_IN;
   localparam int win_words = `SWU_K * `SWU_K * `SWU_EFF_CH;
   localparam int n_out = `SWU_OFM_H * `SWU_OFM_W * win_words;

   typedef enum logic [1:0] {pat_ramp, pat_random, pat_const} pattern_t;

   typedef struct packed {
      pattern_t    pattern;
      logic [7:0]  in_duty;
      logic [7:0]  out_duty;
      logic [15:0] stall;
   } stim_row_t;

   logic  clk;
   logic  resetn;
   word_t in_tdata_i;
   logic  in_tvalid_i;
   logic  in_tready_o;
   word_t out_tdata_o;
   logic  out_tvalid_o;
   logic  out_tready_i;

   stim_row_t stim_tab [n_rows];
   word_t     img [n_rows][frame_in];
   word_t     exp_tab [n_rows][n_out];
   int        cycles;
   int        cycle_limit;
   logic      prev_out_valid;
   logic      prev_out_ready;
   word_t     prev_out_data;
   logic      in_taken;
   int        ahead;

   swu_top swu_top_i (
      .clk          (clk),
      .resetn       (resetn),
      .in_tdata_i   (in_tdata_i),
      .in_tvalid_i  (in_tvalid_i),
      .in_tready_o  (in_tready_o),
      .out_tdata_o  (out_tdata_o),
      .out_tvalid_o (out_tvalid_o),
      .out_tready_i (out_tready_i)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // checking and failure
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want);
         $display("Test FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "run aborted");
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         stop_run("timeout, the output stream did not complete in time");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // input image and expected window stream of one row
   task automatic build_expected(input int r);
      int k;
      int idx;
      k = 0;
      for (int n = 0; n < frame_in; n++) begin
         case (stim_tab[r].pattern)
            pat_ramp:   img[r][n] = word_t'(16'(n) * 16'h0123 + 16'(r) * 16'h1111);
            pat_random: img[r][n] = word_t'(16'($urandom));
            default:    img[r][n] = word_t'(16'h5a3c ^ 16'(r));
         endcase
      end
      for (int oy = 0; oy < `SWU_OFM_H; oy++) begin
         for (int ox = 0; ox < `SWU_OFM_W; ox++) begin
            for (int kh = 0; kh < `SWU_K; kh++) begin
               for (int kw = 0; kw < `SWU_K; kw++) begin
                  for (int ch = 0; ch < `SWU_EFF_CH; ch++) begin
                     idx = ((oy + kh) * `SWU_IFM_W + ox + kw) * `SWU_EFF_CH + ch;
                     exp_tab[r][k] = img[r][idx];
                     k++;
                  end
               end
            end
         end
      end
   endtask

   // worst case cycles for one row at its lowest duty
   function automatic int row_budget(input stim_row_t row);
      int duty;
      duty = (row.in_duty < row.out_duty) ? int'(row.in_duty) : int'(row.out_duty);
      return 4 * (frame_in + n_out) * 100 / duty + int'(row.stall);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // one frame through the DUT
   //////////////////////////////////////////////////////////////////////

   task automatic run_row(input int r);
      stim_row_t row;
      int        in_cnt;
      int        out_cnt;
      int        cyc;
      int        wi;
      int        bound;
      row = stim_tab[r];
      in_cnt = ahead;
      ahead = 0;
      out_cnt = 0;
      cyc = 0;
      while (out_cnt < n_out) begin
         @(negedge clk);
         // stalled output must not change
         if (prev_out_valid && !prev_out_ready) begin
            check_value("out_tvalid_o", 32'(out_tvalid_o), 32'd1);
            check_value("out_tdata_o", 32'(out_tdata_o), 32'(prev_out_data));
         end
         // a word offered but not taken stays on the bus
         if (!in_tvalid_i || in_taken) begin
            if (in_cnt < frame_in) begin
               if (($urandom % 100) < row.in_duty) begin
                  in_tvalid_i = 1'b1;
                  in_tdata_i = img[r][in_cnt];
               end else begin
                  in_tvalid_i = 1'b0;
               end
            end else if (r + 1 < n_rows && ahead == 0) begin
               // first word of the next frame waits for the restart
               in_tvalid_i = 1'b1;
               in_tdata_i = img[r + 1][0];
            end else begin
               in_tvalid_i = 1'b0;
            end
         end
         if (cyc < int'(row.stall)) begin
            out_tready_i = 1'b0;
         end else begin
            out_tready_i = ($urandom % 100) < row.out_duty;
         end
         in_taken = in_tvalid_i && in_tready_o;
         if (in_taken && in_cnt < frame_in) begin
            in_cnt++;
         end else if (in_taken) begin
            if (out_cnt + 2 < n_out) begin
               stop_run("next frame input accepted before the frame was read out");
            end
            ahead = 1;
         end
         // window base from delivered words plus the two that may be in flight
         wi = (out_cnt + 2) / win_words;
         if (wi < `SWU_OFM_H * `SWU_OFM_W) begin
            bound = ((wi / `SWU_OFM_W) * `SWU_IFM_W + wi % `SWU_OFM_W) * `SWU_EFF_CH;
            if (in_cnt > bound + `SWU_BUF_WORDS) begin
               stop_run("input accepted beyond the free space of the window buffer");
            end
         end
         if (out_tvalid_o && out_tready_i) begin
            check_value("out_tdata_o", 32'(out_tdata_o), 32'(exp_tab[r][out_cnt]));
            out_cnt++;
         end
         prev_out_valid = out_tvalid_o;
         prev_out_ready = out_tready_i;
         prev_out_data = out_tdata_o;
         cyc++;
      end
      check_value("accepted inputs", 32'(in_cnt), 32'(frame_in));
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      resetn = 1'b0;
      in_tdata_i = '0;
      in_tvalid_i = 1'b0;
      out_tready_i = 1'b0;
      cycles = 0;
      prev_out_valid = 1'b0;
      prev_out_ready = 1'b0;
      prev_out_data = '0;
      in_taken = 1'b0;
      ahead = 0;
      void'($urandom(rand_seed));

      stim_tab[0] = '{pat_ramp, 8'd100, 8'd100, 16'd0};
      stim_tab[1] = '{pat_ramp, 8'd100, 8'd30, 16'd0};
      stim_tab[2] = '{pat_const, 8'd40, 8'd100, 16'd0};
      stim_tab[3] = '{pat_random, 8'd50, 8'd50, 16'd0};
      stim_tab[4] = '{pat_ramp, 8'd100, 8'd100, 16'd200};

      cycle_limit = 1000 + reset_cycles;
      for (int r = 0; r < n_rows; r++) begin
         cycle_limit += row_budget(stim_tab[r]);
         build_expected(r);
      end

      repeat (reset_cycles) @(negedge clk);
      resetn = 1'b1;
      @(negedge clk);
      check_value("out_tvalid_o", 32'(out_tvalid_o), 32'd0);
      check_value("in_tready_o", 32'(in_tready_o), 32'd1);

      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end

      // nothing may follow the last frame
      @(negedge clk);
      in_tvalid_i = 1'b0;
      out_tready_i = 1'b1;
      repeat (20) begin
         @(negedge clk);
         check_value("out_tvalid_o", 32'(out_tvalid_o), 32'd0);
      end

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/swu_stream_pkg.sv
rtl/swu_geom_pkg.sv
rtl/swu_input_ctrl.sv
rtl/swu_window_ram.sv
rtl/swu_window_seq.sv
rtl/swu_output_stage.sv
rtl/swu_top.sv
testbench/swu_tb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = swu_tb
FLIST = flist.f
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
